// ==== logic/fe_consts.svh ====
`ifndef FE_CONSTS_SVH
`define FE_CONSTS_SVH

// address and instruction widths
`define FE_ADDR_W 32
`define FE_INSTR_W 32

// fetch block geometry, two 32-bit words per block
`define FE_SLOTS 2
`define FE_BLOCK_W 64
`define FE_BLOCK_BITS 3

// predictor and queue sizes
`define FE_BHT_ENTRIES 16
`define FE_QUEUE_DEPTH 8

`endif

// ==== logic/fe_pkg.sv ====
`default_nettype none

`include "fe_consts.svh"

package fe_pkg;

  typedef logic [`FE_ADDR_W-1:0] addr_t;
  typedef logic [`FE_INSTR_W-1:0] instr_t;

  // major opcodes seen by the scanner
  typedef enum logic [6:0] {
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_OTHER  = 7'b0010011
  } opcode_e;

  // control-flow kind of one slot
  typedef enum logic [1:0] {
    CF_NONE   = 2'd0,
    CF_BRANCH = 2'd1,
    CF_JUMP   = 2'd2
  } cf_e;

  // single outstanding fetch block
  typedef enum logic [1:0] {
    PC_IDLE     = 2'd0,
    PC_WAIT_RSP = 2'd1,
    PC_DROP     = 2'd2
  } pc_state_e;

endpackage

`default_nettype wire

// ==== logic/fe_pc_gen.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_pc_gen (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  fe_pkg::addr_t     boot_addr_i,
  input  logic              flush_i,
  input  fe_pkg::addr_t     flush_pc_i,
  input  logic              mispredict_i,
  input  fe_pkg::addr_t     mispredict_pc_i,
  input  logic              redirect_valid_i,
  input  fe_pkg::addr_t     redirect_pc_i,
  input  logic              blk_valid_i,
  input  logic              queue_ready_i,
  output logic              mem_req_valid_o,
  output fe_pkg::addr_t     mem_req_addr_o,
  input  logic              mem_req_ready_i,
  input  logic              mem_rsp_valid_i,
  output logic              rsp_accept_o,
  output fe_pkg::addr_t     fetch_pc_o
);

  fe_pkg::pc_state_e state_q, state_d;
  fe_pkg::addr_t     npc_q, npc_d;
  fe_pkg::addr_t     req_pc;
  fe_pkg::addr_t     fetch_pc_q;
  fe_pkg::addr_t     stale_addr_q;
  logic              rst_load_q;
  logic              stale_q;
  logic              kill;
  logic              req_hs;

  assign kill = flush_i || mispredict_i;

  // first cycle out of reset fetches straight from the boot address
  assign req_pc = rst_load_q ? boot_addr_i : npc_q;

  // ------------------------------
  // request channel
  // ------------------------------
  assign mem_req_valid_o = (state_q == fe_pkg::PC_IDLE) && queue_ready_i;
  // a request pending across a kill keeps its address until accepted
  assign mem_req_addr_o  = stale_q ? stale_addr_q :
                           {req_pc[`FE_ADDR_W-1:`FE_BLOCK_BITS], {`FE_BLOCK_BITS{1'b0}}};
  assign req_hs          = mem_req_valid_o && mem_req_ready_i;

  // response belongs to a live fetch
  assign rsp_accept_o = (state_q == fe_pkg::PC_WAIT_RSP) && mem_rsp_valid_i && !kill;
  assign fetch_pc_o   = fetch_pc_q;

  // ------------------------------
  // next pc, lowest priority first
  // ------------------------------
  always_comb begin
    npc_d = req_pc;
    // a request already made stale keeps the redirected pc
    if (req_hs && !stale_q) begin
      npc_d = {req_pc[`FE_ADDR_W-1:`FE_BLOCK_BITS] + 1'b1, {`FE_BLOCK_BITS{1'b0}}};
    end
    if (redirect_valid_i) begin
      npc_d = redirect_pc_i;
    end
    if (mispredict_i) begin
      npc_d = mispredict_pc_i;
    end
    if (flush_i) begin
      npc_d = flush_pc_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      fe_pkg::PC_IDLE: begin
        if (req_hs) begin
          state_d = (stale_q || kill) ? fe_pkg::PC_DROP : fe_pkg::PC_WAIT_RSP;
        end
      end
      fe_pkg::PC_WAIT_RSP: begin
        if (kill && !mem_rsp_valid_i && !blk_valid_i) begin
          // block still in memory, swallow it when it shows up
          state_d = fe_pkg::PC_DROP;
        end else if (blk_valid_i || (kill && mem_rsp_valid_i)) begin
          state_d = fe_pkg::PC_IDLE;
        end
      end
      fe_pkg::PC_DROP: begin
        if (mem_rsp_valid_i) begin
          state_d = fe_pkg::PC_IDLE;
        end
      end
      default: state_d = fe_pkg::PC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= fe_pkg::PC_IDLE;
      npc_q        <= '0;
      rst_load_q   <= 1'b1;
      stale_q      <= 1'b0;
      stale_addr_q <= '0;
    end else begin
      state_q    <= state_d;
      npc_q      <= npc_d;
      rst_load_q <= 1'b0;
      if (req_hs) begin
        stale_q <= 1'b0;
      end else if (mem_req_valid_o && kill) begin
        // address must hold until accepted, so mark it for dropping
        stale_q      <= 1'b1;
        stale_addr_q <= mem_req_addr_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      fetch_pc_q <= req_pc;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fe_fetch_align.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_fetch_align (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           kill_i,
  input  logic                           rsp_accept_i,
  input  logic [`FE_BLOCK_W-1:0]         rsp_data_i,
  input  fe_pkg::addr_t                  fetch_pc_i,
  output logic                           blk_valid_o,
  output fe_pkg::instr_t [`FE_SLOTS-1:0] slot_instr_o,
  output fe_pkg::addr_t  [`FE_SLOTS-1:0] slot_pc_o,
  output logic [`FE_SLOTS-1:0]           slot_valid_o
);

  localparam int unsigned off_w = `FE_BLOCK_BITS - 2;

  logic                   valid_q;
  logic [`FE_BLOCK_W-1:0] data_q;
  fe_pkg::addr_t          pc_q;
  fe_pkg::addr_t          base_pc;
  logic [off_w-1:0]       word_off;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rsp_accept_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_accept_i) begin
      data_q <= rsp_data_i;
      pc_q   <= fetch_pc_i;
    end
  end

  // blk_valid still tells pc_gen the block is done, even when killed
  assign blk_valid_o = valid_q;
  assign base_pc     = {pc_q[`FE_ADDR_W-1:`FE_BLOCK_BITS], {`FE_BLOCK_BITS{1'b0}}};
  assign word_off    = pc_q[`FE_BLOCK_BITS-1:2];

  // slot 0 is the low word of the block
  for (genvar i = 0; i < `FE_SLOTS; i++) begin : gen_slot
    assign slot_instr_o[i] = data_q[i*`FE_INSTR_W +: `FE_INSTR_W];
    assign slot_pc_o[i]    = base_pc + fe_pkg::addr_t'(i * 4);
    // words before the target address are not part of the stream
    assign slot_valid_o[i] = valid_q && !kill_i && (i >= word_off);
  end

endmodule

`default_nettype wire

// ==== logic/fe_instr_scan.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_instr_scan (
  input  fe_pkg::instr_t instr_i,
  output fe_pkg::cf_e    cf_o,
  output fe_pkg::addr_t  imm_o
);

  fe_pkg::opcode_e opcode;
  fe_pkg::addr_t   imm_b;
  fe_pkg::addr_t   imm_j;

  assign opcode = fe_pkg::opcode_e'(instr_i[6:0]);

  // b-type offset, bit 0 always zero
  assign imm_b = {{(`FE_ADDR_W-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // j-type offset
  assign imm_j = {{(`FE_ADDR_W-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    cf_o  = fe_pkg::CF_NONE;
    imm_o = '0;
    case (opcode)
      fe_pkg::OPC_BRANCH: begin
        cf_o  = fe_pkg::CF_BRANCH;
        imm_o = imm_b;
      end
      fe_pkg::OPC_JAL: begin
        cf_o  = fe_pkg::CF_JUMP;
        imm_o = imm_j;
      end
      // jalr target is register based, fetch just falls through
      fe_pkg::OPC_JALR, fe_pkg::OPC_OTHER: begin
        cf_o = fe_pkg::CF_NONE;
      end
      default: begin
        cf_o = fe_pkg::CF_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/fe_bht.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_bht (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  fe_pkg::addr_t [`FE_SLOTS-1:0] rd_pc_i,
  output logic [`FE_SLOTS-1:0]          rd_taken_o,
  input  logic                          upd_valid_i,
  input  fe_pkg::addr_t                 upd_pc_i,
  input  logic                          upd_taken_i
);

  localparam int unsigned idx_w = $clog2(`FE_BHT_ENTRIES);

  // 2-bit saturating counters, msb is the prediction
  logic [1:0]       cnt_q [`FE_BHT_ENTRIES];
  logic [idx_w-1:0] upd_idx;

  assign upd_idx = upd_pc_i[idx_w+1:2];

  // ------------------------------
  // per-slot lookup
  // ------------------------------
  for (genvar i = 0; i < `FE_SLOTS; i++) begin : gen_rd
    assign rd_taken_o[i] = cnt_q[rd_pc_i[i][idx_w+1:2]][1];
  end

  // ------------------------------
  // training from resolved branches
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // weakly not taken
      for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (upd_valid_i) begin
      if (upd_taken_i && (cnt_q[upd_idx] != 2'b11)) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
      end else if (!upd_taken_i && (cnt_q[upd_idx] != 2'b00)) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/fe_predict.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_predict (
  input  logic                           blk_valid_i,
  input  logic [`FE_SLOTS-1:0]           slot_valid_i,
  input  fe_pkg::addr_t  [`FE_SLOTS-1:0] slot_pc_i,
  input  fe_pkg::instr_t [`FE_SLOTS-1:0] slot_instr_i,
  input  fe_pkg::cf_e    [`FE_SLOTS-1:0] slot_cf_i,
  input  fe_pkg::addr_t  [`FE_SLOTS-1:0] slot_imm_i,
  input  logic [`FE_SLOTS-1:0]           bht_taken_i,
  output logic                           redirect_valid_o,
  output fe_pkg::addr_t                  redirect_pc_o,
  output logic                           push_o,
  output logic [`FE_SLOTS-1:0]           push_mask_o,
  output logic [`FE_SLOTS-1:0]           push_taken_o
);

  logic [`FE_SLOTS-1:0] slot_hit;
  logic                 found;

  // jal always, branch only when its counter says taken
  // words without the 32-bit length code never steer fetch
  for (genvar i = 0; i < `FE_SLOTS; i++) begin : gen_hit
    assign slot_hit[i] = slot_valid_i[i] && (slot_instr_i[i][1:0] == 2'b11) &&
                         ((slot_cf_i[i] == fe_pkg::CF_JUMP) ||
                          ((slot_cf_i[i] == fe_pkg::CF_BRANCH) && bht_taken_i[i]));
  end

  // lowest slot wins, everything after it is trimmed
  always_comb begin
    found         = 1'b0;
    push_mask_o   = '0;
    push_taken_o  = '0;
    redirect_pc_o = '0;
    for (int i = 0; i < `FE_SLOTS; i++) begin
      if (!found && slot_valid_i[i]) begin
        push_mask_o[i] = 1'b1;
        if (slot_hit[i]) begin
          found           = 1'b1;
          push_taken_o[i] = 1'b1;
          redirect_pc_o   = slot_pc_i[i] + slot_imm_i[i];
        end
      end
    end
  end

  assign redirect_valid_o = blk_valid_i && found;
  assign push_o           = blk_valid_i && (push_mask_o != '0);

endmodule

`default_nettype wire

// ==== logic/fe_instr_queue.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_instr_queue (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic                           push_i,
  input  logic [`FE_SLOTS-1:0]           push_mask_i,
  input  fe_pkg::addr_t  [`FE_SLOTS-1:0] push_pc_i,
  input  fe_pkg::instr_t [`FE_SLOTS-1:0] push_instr_i,
  input  logic [`FE_SLOTS-1:0]           push_taken_i,
  output logic                           queue_ready_o,
  output logic                           entry_valid_o,
  output fe_pkg::addr_t                  entry_pc_o,
  output fe_pkg::instr_t                 entry_instr_o,
  output logic                           entry_taken_o,
  input  logic                           entry_ready_i
);

  localparam int unsigned ptr_w = $clog2(`FE_QUEUE_DEPTH);
  // room for a whole block
  localparam logic [ptr_w:0] ready_lim = `FE_QUEUE_DEPTH - `FE_SLOTS;

  fe_pkg::addr_t               pc_mem    [`FE_QUEUE_DEPTH];
  fe_pkg::instr_t              instr_mem [`FE_QUEUE_DEPTH];
  logic [`FE_QUEUE_DEPTH-1:0]  taken_mem;
  logic [ptr_w-1:0]            rd_ptr_q;
  logic [ptr_w-1:0]            wr_ptr_q;
  logic [ptr_w:0]              count_q;
  logic [ptr_w-1:0]            wr_idx [`FE_SLOTS];
  logic [`FE_SLOTS-1:0]        wr_en;
  logic [ptr_w:0]              n_push;
  logic                        pop;

  // ------------------------------
  // packed write of masked slots
  // ------------------------------
  always_comb begin
    n_push = '0;
    for (int i = 0; i < `FE_SLOTS; i++) begin
      wr_en[i]  = push_i && push_mask_i[i] && !clear_i;
      wr_idx[i] = wr_ptr_q + n_push[ptr_w-1:0];
      if (wr_en[i]) begin
        n_push = n_push + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `FE_SLOTS; i++) begin
      if (wr_en[i]) begin
        pc_mem[wr_idx[i]]    <= push_pc_i[i];
        instr_mem[wr_idx[i]] <= push_instr_i[i];
        taken_mem[wr_idx[i]] <= push_taken_i[i];
      end
    end
  end

  // ------------------------------
  // pointers and fill level
  // ------------------------------
  assign pop = entry_valid_o && entry_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + n_push[ptr_w-1:0];
      rd_ptr_q <= rd_ptr_q + ptr_w'(pop);
      count_q  <= count_q + n_push - (ptr_w+1)'(pop);
    end
  end

  assign queue_ready_o = (count_q <= ready_lim);
  assign entry_valid_o = (count_q != '0);
  assign entry_pc_o    = pc_mem[rd_ptr_q];
  assign entry_instr_o = instr_mem[rd_ptr_q];
  assign entry_taken_o = taken_mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== logic/fe_frontend.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_frontend (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fe_pkg::addr_t          boot_addr_i,
  input  logic                   flush_i,
  input  fe_pkg::addr_t          flush_pc_i,
  input  logic                   res_valid_i,
  input  fe_pkg::addr_t          res_pc_i,
  input  logic                   res_is_branch_i,
  input  logic                   res_taken_i,
  input  logic                   res_mispredict_i,
  input  fe_pkg::addr_t          res_target_i,
  output logic                   mem_req_valid_o,
  output fe_pkg::addr_t          mem_req_addr_o,
  input  logic                   mem_req_ready_i,
  input  logic                   mem_rsp_valid_i,
  input  logic [`FE_BLOCK_W-1:0] mem_rsp_data_i,
  output logic                   entry_valid_o,
  output fe_pkg::addr_t          entry_pc_o,
  output fe_pkg::instr_t         entry_instr_o,
  output logic                   entry_taken_o,
  input  logic                   entry_ready_i
);

  logic                           mispredict;
  logic                           kill;
  logic                           bht_upd;
  logic                           rsp_accept;
  logic                           blk_valid;
  logic                           queue_ready;
  logic                           redirect_valid;
  fe_pkg::addr_t                  redirect_pc;
  fe_pkg::addr_t                  fetch_pc;
  fe_pkg::instr_t [`FE_SLOTS-1:0] slot_instr;
  fe_pkg::addr_t  [`FE_SLOTS-1:0] slot_pc;
  logic [`FE_SLOTS-1:0]           slot_valid;
  fe_pkg::cf_e    [`FE_SLOTS-1:0] slot_cf;
  fe_pkg::addr_t  [`FE_SLOTS-1:0] slot_imm;
  logic [`FE_SLOTS-1:0]           bht_taken;
  logic                           push;
  logic [`FE_SLOTS-1:0]           push_mask;
  logic [`FE_SLOTS-1:0]           push_taken;

  // eret, trap and commit redirects all arrive as flush_i
  assign mispredict = res_valid_i && res_mispredict_i;
  assign kill       = mispredict || flush_i;
  assign bht_upd    = res_valid_i && res_is_branch_i;

  fe_pc_gen i_fe_pc_gen (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .boot_addr_i      (boot_addr_i),
    .flush_i          (flush_i),
    .flush_pc_i       (flush_pc_i),
    .mispredict_i     (mispredict),
    .mispredict_pc_i  (res_target_i),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .blk_valid_i      (blk_valid),
    .queue_ready_i    (queue_ready),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .rsp_accept_o     (rsp_accept),
    .fetch_pc_o       (fetch_pc)
  );

  fe_fetch_align i_fe_fetch_align (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .kill_i       (kill),
    .rsp_accept_i (rsp_accept),
    .rsp_data_i   (mem_rsp_data_i),
    .fetch_pc_i   (fetch_pc),
    .blk_valid_o  (blk_valid),
    .slot_instr_o (slot_instr),
    .slot_pc_o    (slot_pc),
    .slot_valid_o (slot_valid)
  );

  // ------------------------------
  // one scanner per slot
  // ------------------------------
  for (genvar i = 0; i < `FE_SLOTS; i++) begin : gen_scan
    fe_instr_scan i_fe_instr_scan (
      .instr_i (slot_instr[i]),
      .cf_o    (slot_cf[i]),
      .imm_o   (slot_imm[i])
    );
  end

  fe_bht i_fe_bht (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_pc_i     (slot_pc),
    .rd_taken_o  (bht_taken),
    .upd_valid_i (bht_upd),
    .upd_pc_i    (res_pc_i),
    .upd_taken_i (res_taken_i)
  );

  fe_predict i_fe_predict (
    .blk_valid_i      (blk_valid),
    .slot_valid_i     (slot_valid),
    .slot_pc_i        (slot_pc),
    .slot_instr_i     (slot_instr),
    .slot_cf_i        (slot_cf),
    .slot_imm_i       (slot_imm),
    .bht_taken_i      (bht_taken),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .push_o           (push),
    .push_mask_o      (push_mask),
    .push_taken_o     (push_taken)
  );

  fe_instr_queue i_fe_instr_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (kill),
    .push_i        (push),
    .push_mask_i   (push_mask),
    .push_pc_i     (slot_pc),
    .push_instr_i  (slot_instr),
    .push_taken_i  (push_taken),
    .queue_ready_o (queue_ready),
    .entry_valid_o (entry_valid_o),
    .entry_pc_o    (entry_pc_o),
    .entry_instr_o (entry_instr_o),
    .entry_taken_o (entry_taken_o),
    .entry_ready_i (entry_ready_i)
  );

endmodule

`default_nettype wire

// ==== dv/fe_props.sv ====
`default_nettype none

module fe_props (
  input logic           clk_i,
  input logic           rst_ni,
  input logic           kill_i,
  input logic           mem_req_valid_i,
  input logic           mem_req_ready_i,
  input fe_pkg::addr_t  mem_req_addr_i,
  input logic           mem_rsp_valid_i,
  input logic           entry_valid_i,
  input logic           entry_ready_i,
  input fe_pkg::addr_t  entry_pc_i,
  input fe_pkg::instr_t entry_instr_i,
  input logic           entry_taken_i
);

  logic pend_q;

  // one block in flight between request handshake and response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
    end else begin
      if (mem_rsp_valid_i) begin
        pend_q <= 1'b0;
      end
      if (mem_req_valid_i && mem_req_ready_i) begin
        pend_q <= 1'b1;
      end
    end
  end

  // ------------------------------
  // handshake rules
  // ------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i && !mem_req_ready_i |=>
      mem_req_valid_i && $stable(mem_req_addr_i))
    else $error("memory request dropped or changed before ready");

  // a flush or mispredict empties the queue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    entry_valid_i && !entry_ready_i && !kill_i |=>
      entry_valid_i && $stable(entry_pc_i) && $stable(entry_instr_i) &&
      $stable(entry_taken_i))
    else $error("entry dropped or changed before ready");

  assert property (@(posedge clk_i) !rst_ni |=> !entry_valid_i)
    else $error("entry valid right after reset");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_valid_i |-> pend_q)
    else $error("memory response without an outstanding request");

endmodule

bind fe_frontend fe_props i_fe_props (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .kill_i          (kill),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_ready_i (mem_req_ready_i),
  .mem_req_addr_i  (mem_req_addr_o),
  .mem_rsp_valid_i (mem_rsp_valid_i),
  .entry_valid_i   (entry_valid_o),
  .entry_ready_i   (entry_ready_i),
  .entry_pc_i      (entry_pc_o),
  .entry_instr_i   (entry_instr_o),
  .entry_taken_i   (entry_taken_o)
);

`default_nettype wire

// ==== dv/fe_tb.sv ====
`default_nettype none

`include "fe_consts.svh"

module fe_tb;

  localparam int n_entries = 8;
  localparam int wait_limit = 400;
  localparam logic [31:0] train_pc = 32'h0000_0408;
  // long run of nops, used as a boot address before a flush
  localparam logic [31:0] idle_pc = 32'h0000_0800;

  logic                   clk_i;
  logic                   rst_ni;
  fe_pkg::addr_t          boot_addr_i;
  logic                   flush_i;
  fe_pkg::addr_t          flush_pc_i;
  logic                   res_valid_i;
  fe_pkg::addr_t          res_pc_i;
  logic                   res_is_branch_i;
  logic                   res_taken_i;
  logic                   res_mispredict_i;
  fe_pkg::addr_t          res_target_i;
  logic                   mem_req_valid_o;
  fe_pkg::addr_t          mem_req_addr_o;
  logic                   mem_req_ready_i;
  logic                   mem_rsp_valid_i;
  logic [`FE_BLOCK_W-1:0] mem_rsp_data_i;
  logic                   entry_valid_o;
  fe_pkg::addr_t          entry_pc_o;
  fe_pkg::instr_t         entry_instr_o;
  logic                   entry_taken_o;
  logic                   entry_ready_i;

  logic [31:0] rng_state = 32'h85ad;
  logic [31:0] rnd;
  int          cyc = 0;
  int          next_lat = 1;
  int          rsp_due = 0;
  logic        busy = 1'b0;
  logic [31:0] rsp_addr = '0;
  logic        stall_en;
  int          n_errors;
  int          n_checked;

  logic [31:0] got_pc [$];
  logic [31:0] got_instr [$];
  logic        got_taken [$];
  logic [31:0] exp_pc [$];
  logic [31:0] exp_instr [$];
  logic        exp_taken [$];

  // row table, mode 0 boots at start, 1 flushes to it, 2 mispredicts to it
  string       row_name [$];
  int          row_mode [$];
  logic [31:0] row_start [$];
  int          row_train [$];
  logic        row_busy [$];
  logic        row_stall [$];

  fe_frontend i_fe_frontend (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .boot_addr_i      (boot_addr_i),
    .flush_i          (flush_i),
    .flush_pc_i       (flush_pc_i),
    .res_valid_i      (res_valid_i),
    .res_pc_i         (res_pc_i),
    .res_is_branch_i  (res_is_branch_i),
    .res_taken_i      (res_taken_i),
    .res_mispredict_i (res_mispredict_i),
    .res_target_i     (res_target_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_data_i   (mem_rsp_data_i),
    .entry_valid_o    (entry_valid_o),
    .entry_pc_o       (entry_pc_o),
    .entry_instr_o    (entry_instr_o),
    .entry_taken_o    (entry_taken_o),
    .entry_ready_i    (entry_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // program image, everything else reads as addi x0, x0, 0
  function automatic logic [31:0] prog_word(input logic [31:0] addr);
    case (addr)
      32'h0000_010c: return 32'h0000_8067;  // jalr x0, 0(x1)
      32'h0000_0300: return 32'h0400_006f;  // jal x0, +0x40
      32'h0000_0304: return 32'h0010_0093;  // addi x1, x0, 1
      32'h0000_0408: return 32'h0200_0063;  // beq x0, x0, +0x20
      default:       return 32'h0000_0013;
    endcase
  endfunction

  function automatic logic [31:0] j_offset(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] b_offset(input logic [31:0] w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  // ------------------------------
  // memory model and decode side
  // ------------------------------
  always @(negedge clk_i) begin
    mem_rsp_valid_i = rst_ni && busy && (cyc == rsp_due);
    mem_rsp_data_i  = {prog_word(rsp_addr + 32'd4), prog_word(rsp_addr)};
    rng_state       = xorshift32(rng_state);
    rnd             = rng_state;
    mem_req_ready_i = (rnd[1:0] != 2'b00);
    next_lat        = 1 + int'(rnd[3:2]);
    entry_ready_i   = stall_en ? rnd[4] : 1'b1;
  end

  // handshakes seen at the clock edge, entries taken before a kill are dropped
  always @(posedge clk_i) begin
    cyc = cyc + 1;
    if (!rst_ni) begin
      busy = 1'b0;
      got_pc.delete();
      got_instr.delete();
      got_taken.delete();
    end else begin
      if (mem_rsp_valid_i) begin
        busy = 1'b0;
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        busy     = 1'b1;
        rsp_addr = mem_req_addr_o;
        rsp_due  = cyc + next_lat - 1;
      end
      if (flush_i || (res_valid_i && res_mispredict_i)) begin
        got_pc.delete();
        got_instr.delete();
        got_taken.delete();
      end else if (entry_valid_o && entry_ready_i) begin
        got_pc.push_back(entry_pc_o);
        got_instr.push_back(entry_instr_o);
        got_taken.push_back(entry_taken_o);
      end
    end
  end

  task automatic add_row(input string name, input int mode, input logic [31:0] start,
                         input int n_train, input logic wait_busy, input logic stall);
    row_name.push_back(name);
    row_mode.push_back(mode);
    row_start.push_back(start);
    row_train.push_back(n_train);
    row_busy.push_back(wait_busy);
    row_stall.push_back(stall);
  endtask

  // reference stream: jal always taken, branch taken on counter msb
  task automatic build_expected(input logic [31:0] start, input int n_train);
    logic [1:0]  cnt [16];
    logic [31:0] pc;
    logic [31:0] w;
    for (int i = 0; i < 16; i++) begin
      cnt[i] = 2'b01;
    end
    for (int k = 0; k < n_train; k++) begin
      if (cnt[train_pc[5:2]] != 2'b11) begin
        cnt[train_pc[5:2]] = cnt[train_pc[5:2]] + 2'd1;
      end
    end
    exp_pc.delete();
    exp_instr.delete();
    exp_taken.delete();
    pc = start;
    repeat (n_entries) begin
      w = prog_word(pc);
      exp_pc.push_back(pc);
      exp_instr.push_back(w);
      if (w[6:0] == 7'b1101111) begin
        exp_taken.push_back(1'b1);
        pc = pc + j_offset(w);
      end else if ((w[6:0] == 7'b1100011) && cnt[pc[5:2]][1]) begin
        exp_taken.push_back(1'b1);
        pc = pc + b_offset(w);
      end else begin
        exp_taken.push_back(1'b0);
        pc = pc + 32'd4;
      end
    end
  endtask

  task automatic run_row(input int r);
    int t;
    build_expected(row_start[r], row_train[r]);
    @(negedge clk_i);
    stall_en    = row_stall[r];
    boot_addr_i = (row_mode[r] == 0) ? row_start[r] : idle_pc;
    rst_ni      = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int k = 0; k < row_train[r]; k++) begin
      res_valid_i      = 1'b1;
      res_pc_i         = train_pc;
      res_is_branch_i  = 1'b1;
      res_taken_i      = 1'b1;
      res_mispredict_i = 1'b0;
      @(negedge clk_i);
    end
    res_valid_i = 1'b0;
    if (row_mode[r] != 0) begin
      t = 0;
      while (row_busy[r] && !(entry_valid_o && busy) && (t < wait_limit)) begin
        @(negedge clk_i);
        t++;
      end
      if (t == wait_limit) begin
        $display("%s: never saw queued entries with a block in flight", row_name[r]);
        n_errors++;
      end
      if (row_mode[r] == 1) begin
        flush_i    = 1'b1;
        flush_pc_i = row_start[r];
      end else begin
        res_valid_i      = 1'b1;
        res_is_branch_i  = 1'b0;
        res_taken_i      = 1'b0;
        res_mispredict_i = 1'b1;
        res_target_i     = row_start[r];
      end
      @(negedge clk_i);
      flush_i          = 1'b0;
      res_valid_i      = 1'b0;
      res_mispredict_i = 1'b0;
    end
    t = 0;
    while ((got_pc.size() < n_entries) && (t < wait_limit)) begin
      @(negedge clk_i);
      t++;
    end
    if (got_pc.size() < n_entries) begin
      $display("%s: only %0d of %0d entries arrived in time", row_name[r], got_pc.size(),
               n_entries);
      n_errors++;
    end else begin
      for (int i = 0; i < n_entries; i++) begin
        n_checked++;
        if ((got_pc[i] !== exp_pc[i]) || (got_taken[i] !== exp_taken[i])) begin
          n_errors++;
          $display("error %s entry %0d: expected pc %h taken %0b, actual pc %h taken %0b",
                   row_name[r], i, exp_pc[i], exp_taken[i], got_pc[i], got_taken[i]);
        end
        if (got_instr[i] !== exp_instr[i]) begin
          n_errors++;
          $display("error %s entry %0d: expected instr %h, actual instr %h",
                   row_name[r], i, exp_instr[i], got_instr[i]);
        end
      end
    end
  endtask

  initial begin
    rst_ni           = 1'b0;
    boot_addr_i      = idle_pc;
    flush_i          = 1'b0;
    flush_pc_i       = '0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_is_branch_i  = 1'b0;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    res_target_i     = '0;
    mem_req_ready_i  = 1'b0;
    mem_rsp_valid_i  = 1'b0;
    mem_rsp_data_i   = '0;
    entry_ready_i    = 1'b0;
    stall_en         = 1'b0;
    n_errors         = 0;
    n_checked        = 0;

    add_row("boot_aligned", 0, 32'h0000_0100, 0, 1'b0, 1'b0);
    add_row("boot_upper_word", 0, 32'h0000_0204, 0, 1'b0, 1'b0);
    add_row("jal_slot0", 0, 32'h0000_0300, 0, 1'b0, 1'b0);
    add_row("branch_untrained", 0, 32'h0000_0400, 0, 1'b0, 1'b0);
    add_row("branch_trained", 1, 32'h0000_0400, 2, 1'b0, 1'b0);
    add_row("flush_in_flight", 1, 32'h0000_0100, 0, 1'b1, 1'b1);
    add_row("mispredict_in_flight", 2, 32'h0000_0304, 0, 1'b1, 1'b1);
    add_row("random_stall", 0, 32'h0000_0100, 0, 1'b0, 1'b1);

    for (int r = 0; r < row_name.size(); r++) begin
      run_row(r);
    end

    $display("checked %0d entries, %0d errors", n_checked, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/fe_pkg.sv
logic/fe_pc_gen.sv
logic/fe_fetch_align.sv
logic/fe_instr_scan.sv
logic/fe_bht.sv
logic/fe_predict.sv
logic/fe_instr_queue.sv
logic/fe_frontend.sv
dv/fe_props.sv
dv/fe_tb.sv
